// ==== common/v_lsu_pkg.sv ====
package v_lsu_pkg;

    // one vector register is one memory line
    localparam int vlen      = 128;
    localparam int n_banks   = 4;
    localparam int word_w    = 32;
    localparam int line_aw   = 8;
    localparam int vreg_aw   = 5;
    localparam int max_group = 4;
    localparam int group_w   = vlen * max_group;

    typedef enum logic [3:0] {
        vlsu_vle8   = 4'd1,
        vlsu_vle16  = 4'd2,
        vlsu_vle32  = 4'd3,
        vlsu_vlse8  = 4'd4,
        vlsu_vlse16 = 4'd5,
        vlsu_vlse32 = 4'd6
    } vlsu_op_t;

    // fractional codes are not supported
    typedef enum logic [2:0] {
        lmul_1 = 3'b000,
        lmul_2 = 3'b001,
        lmul_4 = 3'b010
    } lmul_t;

    typedef struct packed {
        vlsu_op_t             op;
        lmul_t                lmul;
        logic [6:0]           vl;
        logic [line_aw-1:0]   base_line;
        logic [vreg_aw-1:0]   vd;
    } load_req_t;

    typedef struct packed {
        logic                 en;
        logic [line_aw-1:0]   line;
        logic [vlen-1:0]      data;
    } mem_wr_t;

    typedef struct packed {
        logic                 en;
        logic [vreg_aw-1:0]   vd;
        logic [2:0]           nregs;
        logic [group_w-1:0]   data;
    } group_wr_t;

    // unknown lmul codes count as one register
    function automatic logic [2:0] lmul_nregs(input lmul_t lmul);
        logic [2:0] n;
        case (lmul)
            lmul_2:  n = 3'd2;
            lmul_4:  n = 3'd4;
            default: n = 3'd1;
        endcase
        return n;
    endfunction

endpackage

// ==== hdl/data_mem.sv ====
`timescale 1ns/10ps

module data_mem (
    input  logic                          clk,
    input  v_lsu_pkg::mem_wr_t            mem_wr,
    input  logic                          rd_en,
    input  logic [v_lsu_pkg::line_aw-1:0] rd_line,
    output logic [v_lsu_pkg::vlen-1:0]    rd_data
);

    import v_lsu_pkg::*;

    // one array per bank with a shared line index
    for (genvar b = 0; b < n_banks; b++) begin : g_bank
        logic [word_w-1:0] mem [2**line_aw];

        always_ff @(posedge clk) begin
            if (mem_wr.en) begin
                mem[mem_wr.line] <= mem_wr.data[word_w*b +: word_w];
            end
        end

        // bank b drives word b of the line
        always_ff @(posedge clk) begin
            if (rd_en) begin
                rd_data[word_w*b +: word_w] <= mem[rd_line];
            end
        end
    end

endmodule

// ==== hdl/vreg_file.sv ====
`timescale 1ns/10ps

module vreg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  v_lsu_pkg::group_wr_t          group_wr,
    input  logic [v_lsu_pkg::vreg_aw-1:0] rd_idx,
    output logic [v_lsu_pkg::vlen-1:0]    rd_data
);

    import v_lsu_pkg::*;

    localparam int n_vregs = 2**vreg_aw;

    logic [vlen-1:0] regs [n_vregs];

    // register vd+k takes slice k of the group word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < n_vregs; r++) begin
                regs[r] <= '0;
            end
        end else if (group_wr.en) begin
            for (int k = 0; k < max_group; k++) begin
                if (k < group_wr.nregs) begin
                    // index wraps past v31
                    regs[vreg_aw'(group_wr.vd + k)] <= group_wr.data[vlen*k +: vlen];
                end
            end
        end
    end

    assign rd_data = regs[rd_idx];

endmodule

// ==== vlsu/v_load_ctrl.sv ====
`timescale 1ns/10ps

module v_load_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  v_lsu_pkg::load_req_t          load_req,
    output logic                          ack,
    output v_lsu_pkg::load_req_t          hold_req,
    output logic                          rd_en,
    output logic [v_lsu_pkg::line_aw-1:0] rd_line,
    output logic                          beat_valid,
    output logic                          beat_last,
    input  logic                          finish
);

    import v_lsu_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_read,
        s_wait_wr,
        s_ack,
        s_drop
    } state_t;

    state_t     state;
    logic [2:0] beat_cnt;
    logic [2:0] nbeats;
    logic       last_issue;
    logic       is_unit_load;

    assign nbeats       = lmul_nregs(hold_req.lmul);
    assign last_issue   = (beat_cnt == nbeats - 3'd1);
    assign is_unit_load = load_req.op inside {vlsu_vle8, vlsu_vle16, vlsu_vle32};

    // one line per cycle while in READ
    assign rd_en   = (state == s_read);
    assign rd_line = hold_req.base_line + line_aw'(beat_cnt);

    // request is captured once and held for the whole load
    always_ff @(posedge clk) begin
        if (state == s_idle && req) begin
            hold_req <= load_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= s_idle;
            beat_cnt <= '0;
            ack      <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    beat_cnt <= '0;
                    if (req) begin
                        // strided and unknown ops skip the memory entirely
                        state <= is_unit_load ? s_read : s_ack;
                    end
                end
                s_read: begin
                    beat_cnt <= beat_cnt + 3'd1;
                    if (last_issue) begin
                        state <= s_wait_wr;
                    end
                end
                s_wait_wr: begin
                    if (finish) begin
                        ack   <= 1'b1;
                        state <= s_ack;
                    end
                end
                s_ack: begin
                    ack <= 1'b1;
                    // hold ack until the requester lets go
                    if (ack && !req) begin
                        state <= s_drop;
                    end
                end
                s_drop: begin
                    ack   <= 1'b0;
                    state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

    // data comes back one cycle after the read, so the strobes trail rd_en
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_valid <= 1'b0;
            beat_last  <= 1'b0;
        end else begin
            beat_valid <= rd_en;
            beat_last  <= rd_en && last_issue;
        end
    end

endmodule

// ==== vlsu/v_load_assembler.sv ====
`timescale 1ns/10ps

module v_load_assembler (
    input  logic                       clk,
    input  logic                       rst_n,
    input  v_lsu_pkg::load_req_t       hold_req,
    input  logic                       beat_valid,
    input  logic                       beat_last,
    input  logic [v_lsu_pkg::vlen-1:0] rd_data,
    output v_lsu_pkg::group_wr_t       group_wr,
    output logic                       finish
);

    import v_lsu_pkg::*;

    logic [group_w-1:0] shift_q;
    logic               last_q;
    logic [2:0]         nregs;
    logic [8:0]         elem_bytes;
    logic [8:0]         n_bytes;
    logic [group_w-1:0] aligned;
    logic [group_w-1:0] masked;
    logic               wr_en;
    logic [group_w-1:0] wr_data;

    assign nregs = lmul_nregs(hold_req.lmul);

    // newest beat enters at the top, older beats move down
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            shift_q <= {rd_data, shift_q[group_w-1:vlen]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= 1'b0;
        end else begin
            last_q <= beat_valid && beat_last;
        end
    end

    // beat k ends up at bit 128k, unused slots shift out as zero
    assign aligned = shift_q >> ((max_group - int'(nregs)) * vlen);

    always_comb begin
        case (hold_req.op)
            vlsu_vle8:  elem_bytes = 9'd1;
            vlsu_vle16: elem_bytes = 9'd2;
            default:    elem_bytes = 9'd4;
        endcase
    end

    assign n_bytes = {2'b00, hold_req.vl} * elem_bytes;

    // tail bytes past vl elements read as zero
    always_comb begin
        for (int b = 0; b < group_w / 8; b++) begin
            masked[8*b +: 8] = (b < n_bytes) ? aligned[8*b +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (last_q) begin
            wr_data <= masked;
        end
    end

    // vd and nregs come from the held request, stable until the next accept
    assign group_wr = '{en: wr_en, vd: hold_req.vd, nregs: nregs, data: wr_data};
    assign finish   = wr_en;

endmodule

// ==== vlsu/v_loadu.sv ====
`timescale 1ns/10ps

module v_loadu (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  v_lsu_pkg::load_req_t          load_req,
    output logic                          ack,
    output logic                          rd_en,
    output logic [v_lsu_pkg::line_aw-1:0] rd_line,
    input  logic [v_lsu_pkg::vlen-1:0]    rd_data,
    output v_lsu_pkg::group_wr_t          group_wr
);

    import v_lsu_pkg::*;

    // held request shared by both halves
    load_req_t hold_req;
    logic      beat_valid;
    logic      beat_last;
    logic      finish;

    v_load_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .load_req   (load_req),
        .ack        (ack),
        .hold_req   (hold_req),
        .rd_en      (rd_en),
        .rd_line    (rd_line),
        .beat_valid (beat_valid),
        .beat_last  (beat_last),
        .finish     (finish)
    );

    v_load_assembler u_asm (
        .clk        (clk),
        .rst_n      (rst_n),
        .hold_req   (hold_req),
        .beat_valid (beat_valid),
        .beat_last  (beat_last),
        .rd_data    (rd_data),
        .group_wr   (group_wr),
        .finish     (finish)
    );

endmodule

// ==== hdl/v_load_top.sv ====
`timescale 1ns/10ps

module v_load_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  v_lsu_pkg::load_req_t          load_req,
    output logic                          ack,
    input  v_lsu_pkg::mem_wr_t            mem_wr,
    input  logic [v_lsu_pkg::vreg_aw-1:0] rd_idx,
    output logic [v_lsu_pkg::vlen-1:0]    rd_data
);

    import v_lsu_pkg::*;

    logic               mem_rd_en;
    logic [line_aw-1:0] mem_rd_line;
    logic [vlen-1:0]    mem_rd_data;
    group_wr_t          group_wr;

    v_loadu u_loadu (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .load_req (load_req),
        .ack      (ack),
        .rd_en    (mem_rd_en),
        .rd_line  (mem_rd_line),
        .rd_data  (mem_rd_data),
        .group_wr (group_wr)
    );

    // preload port shares the array with the load path
    data_mem u_mem (
        .clk     (clk),
        .mem_wr  (mem_wr),
        .rd_en   (mem_rd_en),
        .rd_line (mem_rd_line),
        .rd_data (mem_rd_data)
    );

    vreg_file u_vrf (
        .clk      (clk),
        .rst_n    (rst_n),
        .group_wr (group_wr),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

endmodule

// ==== dv/v_load_tb.sv ====
`timescale 1ns/10ps

module v_load_tb;

    import v_lsu_pkg::*;

    // one row of the stimulus table
    // hold is the number of extra cycles req stays high after ack
    typedef struct {
        string      name;
        logic [3:0] op;
        logic [2:0] lmul;
        logic [6:0] vl;
        logic [7:0] base;
        logic [4:0] vd;
        int         hold;
    } test_t;

    localparam int ack_wait_limit = 20;

    logic                clk;
    logic                rst_n;
    logic                req;
    load_req_t           load_req;
    logic                ack;
    mem_wr_t             mem_wr;
    logic [vreg_aw-1:0]  rd_idx;
    logic [vlen-1:0]     rd_data;

    logic [vlen-1:0]     mem_model [2**line_aw];
    logic [vlen-1:0]     regs_model [2**vreg_aw];
    test_t               tests [$];

    int                  check_count = 0;
    int                  error_count = 0;
    int                  cycle_count = 0;
    int                  timeout_cycles = 100000;

    v_load_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .load_req (load_req),
        .ack      (ack),
        .mem_wr   (mem_wr),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit counted in clock cycles
    initial begin
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_value(input string what, input logic [vlen-1:0] expected,
                               input logic [vlen-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic add_test(input string name, input logic [3:0] op, input logic [2:0] lmul,
                            input logic [6:0] vl, input logic [7:0] base,
                            input logic [4:0] vd, input int hold);
        test_t t;
        t.name = name;
        t.op   = op;
        t.lmul = lmul;
        t.vl   = vl;
        t.base = base;
        t.vd   = vd;
        t.hold = hold;
        tests.push_back(t);
    endtask

    function automatic bit is_unit(input logic [3:0] op);
        return (op == 4'd1) || (op == 4'd2) || (op == 4'd3);
    endfunction

    // lmul 001 is two registers, 010 is four, anything else is one
    function automatic int group_regs(input logic [2:0] lmul);
        if (lmul == 3'b001) return 2;
        if (lmul == 3'b010) return 4;
        return 1;
    endfunction

    function automatic int elem_bytes(input logic [3:0] op);
        if (op == 4'd1) return 1;
        if (op == 4'd2) return 2;
        return 4;
    endfunction

    // register vd+k takes line base+k, bytes past vl elements read as zero
    task automatic update_model(input test_t t);
        int              n_bytes;
        logic [vlen-1:0] line_val;
        if (!is_unit(t.op)) return;
        n_bytes = int'(t.vl) * elem_bytes(t.op);
        for (int k = 0; k < group_regs(t.lmul); k++) begin
            line_val = mem_model[8'(t.base + k)];
            for (int j = 0; j < vlen / 8; j++) begin
                if ((vlen / 8) * k + j >= n_bytes) begin
                    line_val[8*j +: 8] = 8'h00;
                end
            end
            regs_model[5'(t.vd + k)] = line_val;
        end
    endtask

    // four-phase transfer with order and latency checks
    task automatic run_load(input test_t t);
        int cycles;
        int exp_edge;
        exp_edge = is_unit(t.op) ? group_regs(t.lmul) + 3 : 1;
        @(negedge clk);
        check_value({t.name, " ack before req"}, 1'b0, ack);
        load_req.op        = vlsu_op_t'(t.op);
        load_req.lmul      = lmul_t'(t.lmul);
        load_req.vl        = t.vl;
        load_req.base_line = t.base;
        load_req.vd        = t.vd;
        req = 1'b1;
        cycles = 0;
        while (!ack && cycles < ack_wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!ack) begin
            error_count++;
            $display("test %s: ack never rose within %0d cycles of req", t.name, ack_wait_limit);
            req = 1'b0;
            return;
        end
        check_value({t.name, " ack latency"}, exp_edge, cycles - 1);
        // ack must stay up while the requester is slow to let go
        repeat (t.hold) begin
            @(negedge clk);
            check_value({t.name, " ack held"}, 1'b1, ack);
        end
        req = 1'b0;
        cycles = 0;
        while (ack && cycles < ack_wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (ack) begin
            error_count++;
            $display("test %s: ack stayed high after req was dropped", t.name);
            return;
        end
        // one edge sees req low, the next one drops ack
        check_value({t.name, " ack fall"}, 2, cycles);
    endtask

    task automatic read_back(input string name);
        @(negedge clk);
        rd_idx = '0;
        for (int r = 0; r < 2**vreg_aw; r++) begin
            @(negedge clk);
            check_value($sformatf("%s v%0d", name, r), regs_model[r], rd_data);
            rd_idx = vreg_aw'(r + 1);
        end
    endtask

    initial begin
        int errors_before;
        rst_n    = 1'b0;
        req      = 1'b0;
        load_req = '0;
        mem_wr   = '0;
        rd_idx   = '0;
        void'($urandom(40));

        //       name            op     lmul    vl   base  vd  hold
        add_test("vle32_m1_full", 4'd3, 3'b000, 7'd4, 8'd10, 5'd1, 0);
        add_test("vle32_m2", 4'd3, 3'b001, 7'd8, 8'd20, 5'd4, 0);
        add_test("vle32_m4", 4'd3, 3'b010, 7'd16, 8'd40, 5'd8, 2);
        add_test("vle32_m4_wrap", 4'd3, 3'b010, 7'd16, 8'd254, 5'd30, 0);
        add_test("vle8_tail_m2", 4'd1, 3'b001, 7'd20, 8'd60, 5'd12, 0);
        add_test("vle16_tail_m1", 4'd2, 3'b000, 7'd5, 8'd70, 5'd14, 0);
        add_test("vle8_tail_m4", 4'd1, 3'b010, 7'd37, 8'd80, 5'd16, 1);
        add_test("lmul_011", 4'd3, 3'b011, 7'd16, 8'd90, 5'd20, 0);
        add_test("lmul_111", 4'd2, 3'b111, 7'd8, 8'd100, 5'd21, 0);
        add_test("vlse32_skip", 4'd6, 3'b010, 7'd16, 8'd110, 5'd22, 0);
        add_test("vlse8_hold", 4'd4, 3'b000, 7'd4, 8'd120, 5'd1, 4);
        add_test("vle16_m2_hold", 4'd2, 3'b001, 7'd12, 8'd130, 5'd2, 5);
        add_test("vle8_vl0", 4'd1, 3'b000, 7'd0, 8'd140, 5'd25, 0);

        // reset and preload, then per test handshake plus a 33 cycle read-back
        timeout_cycles = 2**line_aw + 100 + tests.size() * 60;

        for (int l = 0; l < 2**line_aw; l++) begin
            mem_model[l] = {$urandom, $urandom, $urandom, $urandom};
        end
        for (int r = 0; r < 2**vreg_aw; r++) begin
            regs_model[r] = '0;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("after reset ack", 1'b0, ack);

        for (int l = 0; l < 2**line_aw; l++) begin
            mem_wr.en   = 1'b1;
            mem_wr.line = line_aw'(l);
            mem_wr.data = mem_model[l];
            @(negedge clk);
        end
        mem_wr = '0;

        foreach (tests[i]) begin
            errors_before = error_count;
            run_load(tests[i]);
            update_model(tests[i]);
            read_back(tests[i].name);
            if (error_count == errors_before) begin
                $display("test %-16s pass", tests[i].name);
            end else begin
                $display("test %-16s fail, %0d errors", tests[i].name,
                         error_count - errors_before);
            end
        end

        $display("tests: %0d, checks: %0d, errors: %0d", tests.size(), check_count,
                 error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/v_lsu_pkg.sv
hdl/data_mem.sv
hdl/vreg_file.sv
vlsu/v_load_ctrl.sv
vlsu/v_load_assembler.sv
vlsu/v_loadu.sv
hdl/v_load_top.sv
dv/v_load_tb.sv
